// ==== htif_pkg.sv ====
/* Shared AXI channel payloads, console opcodes and HTIF / UART-lite constants.
   Only the AXI fields that the console bridge needs are carried. */
`default_nettype none

package htif_pkg;

    typedef struct packed {
        logic [63:0] addr;
        logic [7:0]  len;    // burst length, 0 for single beat
    } axi_addr_t;

    typedef struct packed {
        logic [63:0] data;
        logic [7:0]  strb;
        logic        last;
    } axi_wdata_t;

    typedef struct packed {
        logic [63:0] data;
        logic        last;
    } axi_rdata_t;

    typedef enum logic [1:0] {
        op_none,
        op_tx,    // putchar
        op_rx     // poll for one byte
    } console_op_t;

    typedef enum logic [2:0] {
        st_idle,
        st_stat_addr,
        st_stat_data,
        st_tx_addr,    // aw and w together
        st_tx_resp,
        st_rx_addr,
        st_rx_data,
        st_recover
    } uart_state_t;

    localparam logic [7:0]  htif_dev_console   = 8'd1;  // tohost bits 63:56
    localparam logic [7:0]  htif_cmd_putchar   = 8'd1;  // tohost bits 55:48

    localparam logic [63:0] uart_fifo_off      = 64'd0; // rx read / tx write
    localparam logic [63:0] uart_stat_off      = 64'd8;
    localparam int          uart_stat_rx_valid = 0;
    localparam int          uart_stat_tx_full  = 3;

    // character goes out on byte lane 4, data bits 39:32
    localparam logic [7:0]  uart_tx_strb       = 8'b0001_0000;

endpackage

`default_nettype wire

// ==== htif_regs.sv ====
/* AXI slave for tohost and fromhost, single beat only; write strobes are ignored.
   Readies stay low from acceptance until session_end, including any console operation. */
`default_nettype none

module htif_regs import htif_pkg::*; #(
    parameter logic [63:0] tohost_addr   = '0,
    parameter logic [63:0] fromhost_addr = '0
) (
    input  logic        clk,
    input  logic        rst,
    input  axi_addr_t   aw,
    input  logic        aw_valid,
    output logic        aw_ready,
    input  axi_wdata_t  w,
    input  logic        w_valid,
    output logic        w_ready,
    output logic        b_valid,
    input  logic        b_ready,
    input  axi_addr_t   ar,
    input  logic        ar_valid,
    output logic        ar_ready,
    output axi_rdata_t  r,
    output logic        r_valid,
    input  logic        r_ready,
    output console_op_t op,
    output logic        op_start,
    output logic [7:0]  tx_byte,
    input  logic        op_done,
    input  logic        rx_valid,
    input  logic [7:0]  rx_byte,
    output logic        session_end
);
    logic [63:0] tohost;
    logic [63:0] fromhost;
    logic [63:0] waddr;
    logic [63:0] wdata;
    logic        aw_held;
    logic        w_held;
    logic        rx_due;     // read of an empty fromhost
    logic        tx_due;

    assign tx_due  = tohost[63:56] == htif_dev_console && tohost[55:48] == htif_cmd_putchar;
    assign tx_byte = tohost[7:0];

    always_ff @(posedge clk) begin
        if (aw_valid && aw_ready)
            waddr <= aw.addr;
        if (w_valid && w_ready)
            wdata <= w.data;
        if (ar_valid && ar_ready) begin
            r.data <= (ar.addr == tohost_addr) ? tohost : fromhost;
            r.last <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_ready    <= 1'b1;
            w_ready     <= 1'b1;
            ar_ready    <= 1'b1;
            b_valid     <= 1'b0;
            r_valid     <= 1'b0;
            aw_held     <= 1'b0;
            w_held      <= 1'b0;
            rx_due      <= 1'b0;
            op          <= op_none;
            op_start    <= 1'b0;
            session_end <= 1'b0;
            tohost      <= '0;
            fromhost    <= '0;
        end else begin
            op_start    <= 1'b0;
            session_end <= 1'b0;
            if (ar_valid && ar_ready) begin
                {aw_ready, w_ready, ar_ready} <= '0;
                r_valid <= 1'b1;
                rx_due  <= ar.addr == fromhost_addr && fromhost == '0;
            end
            if (aw_valid && aw_ready) begin
                aw_ready <= 1'b0;
                ar_ready <= 1'b0;
                aw_held  <= 1'b1;
            end
            if (w_valid && w_ready) begin
                w_ready  <= 1'b0;
                ar_ready <= 1'b0;
                w_held   <= 1'b1;
            end
            if (aw_held && w_held) begin    // both halves in, answer and update
                aw_held <= 1'b0;
                w_held  <= 1'b0;
                b_valid <= 1'b1;
                if (waddr == tohost_addr)
                    tohost <= wdata;
                if (waddr == fromhost_addr)
                    fromhost <= wdata;
            end
            if (b_valid && b_ready) begin
                b_valid <= 1'b0;
                if (tx_due) begin
                    op       <= op_tx;
                    op_start <= 1'b1;
                end else begin
                    session_end <= 1'b1;
                    {aw_ready, w_ready, ar_ready} <= '1;
                end
            end
            if (r_valid && r_ready) begin
                r_valid <= 1'b0;
                if (rx_due) begin
                    op       <= op_rx;
                    op_start <= 1'b1;
                end else begin
                    session_end <= 1'b1;
                    {aw_ready, w_ready, ar_ready} <= '1;
                end
            end
            if (op_done) begin
                if (op == op_tx)
                    tohost <= '0;                 // putchar consumed
                else if (rx_valid)
                    fromhost <= {htif_dev_console, 8'd0, 40'd0, rx_byte};
                op          <= op_none;
                session_end <= 1'b1;
                {aw_ready, w_ready, ar_ready} <= '1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== uart_lite_master.sv ====
/* UART-lite master for one console operation at a time, started by op_start.
   No timeout on any handshake; a full Tx FIFO repeats the status read forever. */
`default_nettype none

module uart_lite_master import htif_pkg::*; #(
    parameter logic [63:0] uart_base = '0
) (
    input  logic        clk,
    input  logic        rst,
    input  console_op_t op,
    input  logic        op_start,
    input  logic [7:0]  tx_byte,
    output axi_addr_t   aw,
    output logic        aw_valid,
    input  logic        aw_ready,
    output axi_wdata_t  w,
    output logic        w_valid,
    input  logic        w_ready,
    input  logic        b_valid,
    output logic        b_ready,
    output axi_addr_t   ar,
    output logic        ar_valid,
    input  logic        ar_ready,
    input  axi_rdata_t  r,
    input  logic        r_valid,
    output logic        r_ready,
    output logic        op_done,
    output logic        rx_valid,
    output logic [7:0]  rx_byte
);
    uart_state_t state;
    console_op_t op_q;
    logic [7:0]  char_q;

    // ar address follows the state, stable while ar_valid is held
    assign ar.addr = uart_base + ((state == st_rx_addr) ? uart_fifo_off : uart_stat_off);
    assign ar.len  = 8'd0;
    assign aw.addr = uart_base + uart_fifo_off;
    assign aw.len  = 8'd0;
    assign w.data  = {24'd0, char_q, 32'd0};
    assign w.strb  = uart_tx_strb;
    assign w.last  = 1'b1;

    always_ff @(posedge clk) begin
        if (state == st_idle && op_start)
            char_q <= tx_byte;
        if (state == st_rx_data && r_valid)
            rx_byte <= r.data[7:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            op_q     <= op_none;
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
            b_ready  <= 1'b0;
            ar_valid <= 1'b0;
            r_ready  <= 1'b0;
            op_done  <= 1'b0;
            rx_valid <= 1'b0;
        end else begin
            op_done <= 1'b0;
            case (state)
                st_idle: if (op_start && op != op_none) begin
                    op_q     <= op;
                    rx_valid <= 1'b0;
                    ar_valid <= 1'b1;                   // status read first
                    state    <= st_stat_addr;
                end
                st_stat_addr: if (ar_ready) begin
                    ar_valid <= 1'b0;
                    r_ready  <= 1'b1;
                    state    <= st_stat_data;
                end
                st_stat_data: if (r_valid) begin
                    r_ready <= 1'b0;
                    if (op_q == op_rx) begin
                        if (r.data[uart_stat_rx_valid]) begin
                            ar_valid <= 1'b1;
                            state    <= st_rx_addr;
                        end else begin
                            state <= st_recover;        // nothing received
                        end
                    end else if (r.data[uart_stat_tx_full]) begin
                        ar_valid <= 1'b1;               // poll again
                        state    <= st_stat_addr;
                    end else begin
                        aw_valid <= 1'b1;
                        w_valid  <= 1'b1;
                        state    <= st_tx_addr;
                    end
                end
                st_tx_addr: begin
                    if (aw_ready)
                        aw_valid <= 1'b0;
                    if (w_ready)
                        w_valid <= 1'b0;
                    if ((aw_ready || !aw_valid) && (w_ready || !w_valid)) begin
                        b_ready <= 1'b1;
                        state   <= st_tx_resp;
                    end
                end
                st_tx_resp: if (b_valid) begin
                    b_ready <= 1'b0;
                    state   <= st_recover;
                end
                st_rx_addr: if (ar_ready) begin
                    ar_valid <= 1'b0;
                    r_ready  <= 1'b1;
                    state    <= st_rx_data;
                end
                st_rx_data: if (r_valid) begin
                    r_ready  <= 1'b0;
                    rx_valid <= 1'b1;
                    state    <= st_recover;
                end
                st_recover: begin
                    op_done <= 1'b1;
                    state   <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== htif_axi_router.sv ====
/* Steers upstream traffic to the HTIF slave and the bus to the UART master during a session.
   No pass-through transaction may be outstanding when an HTIF access starts, and the W of
   an HTIF write must not come before its AW. */
`default_nettype none

module htif_axi_router import htif_pkg::*; #(
    parameter logic [63:0] tohost_addr   = '0,
    parameter logic [63:0] fromhost_addr = '0
) (
    input  logic       clk,
    input  logic       rst,
    input  axi_addr_t  up_aw,
    input  axi_wdata_t up_w,
    input  axi_addr_t  up_ar,
    input  logic       up_aw_valid, up_w_valid, up_b_ready, up_ar_valid, up_r_ready,
    output logic       up_aw_ready, up_w_ready, up_b_valid, up_ar_ready, up_r_valid,
    output axi_rdata_t up_r,
    output axi_addr_t  dn_aw,
    output axi_wdata_t dn_w,
    output axi_addr_t  dn_ar,
    output logic       dn_aw_valid, dn_w_valid, dn_b_ready, dn_ar_valid, dn_r_ready,
    input  logic       dn_aw_ready, dn_w_ready, dn_b_valid, dn_ar_ready, dn_r_valid,
    input  axi_rdata_t dn_r,
    output axi_addr_t  hs_aw,
    output axi_wdata_t hs_w,
    output axi_addr_t  hs_ar,
    output logic       hs_aw_valid, hs_w_valid, hs_b_ready, hs_ar_valid, hs_r_ready,
    input  logic       hs_aw_ready, hs_w_ready, hs_b_valid, hs_ar_ready, hs_r_valid,
    input  axi_rdata_t hs_r,
    input  axi_addr_t  um_aw,
    input  axi_wdata_t um_w,
    input  axi_addr_t  um_ar,
    input  logic       um_aw_valid, um_w_valid, um_b_ready, um_ar_valid, um_r_ready,
    output logic       um_aw_ready, um_w_ready, um_b_valid, um_ar_ready, um_r_valid,
    output axi_rdata_t um_r,
    input  logic       session_end
);
    logic session;
    logic aw_htif;
    logic ar_htif;
    logic hit;
    logic use_local;

    assign aw_htif = up_aw.len == 8'd0 && (up_aw.addr == tohost_addr ||
                                           up_aw.addr == fromhost_addr);
    assign ar_htif = up_ar.len == 8'd0 && (up_ar.addr == tohost_addr ||
                                           up_ar.addr == fromhost_addr);
    assign hit       = (up_aw_valid && aw_htif) || (up_ar_valid && ar_htif);
    assign use_local = hit || (session && !session_end);   // ending session frees the path

    always_ff @(posedge clk) begin
        if (rst)
            session <= 1'b0;
        else if (hit)
            session <= 1'b1;      // a waiting hit keeps it open
        else if (session_end)
            session <= 1'b0;
    end

    // upstream side, non-HTIF requests are held off during a session
    assign up_aw_ready = use_local ? hs_aw_ready && aw_htif : dn_aw_ready;
    assign up_w_ready  = use_local ? hs_w_ready : dn_w_ready;
    assign up_b_valid  = use_local ? hs_b_valid : dn_b_valid;
    assign up_ar_ready = use_local ? hs_ar_ready && ar_htif : dn_ar_ready;
    assign up_r        = use_local ? hs_r : dn_r;
    assign up_r_valid  = use_local ? hs_r_valid : dn_r_valid;

    assign hs_aw       = up_aw;
    assign hs_aw_valid = use_local && up_aw_valid && aw_htif;
    assign hs_w        = up_w;
    assign hs_w_valid  = use_local && up_w_valid;
    assign hs_b_ready  = use_local && up_b_ready;
    assign hs_ar       = up_ar;
    assign hs_ar_valid = use_local && up_ar_valid && ar_htif;
    assign hs_r_ready  = use_local && up_r_ready;

    // bus side
    assign dn_aw       = use_local ? um_aw : up_aw;
    assign dn_aw_valid = use_local ? um_aw_valid : up_aw_valid;
    assign dn_w        = use_local ? um_w : up_w;
    assign dn_w_valid  = use_local ? um_w_valid : up_w_valid;
    assign dn_b_ready  = use_local ? um_b_ready : up_b_ready;
    assign dn_ar       = use_local ? um_ar : up_ar;
    assign dn_ar_valid = use_local ? um_ar_valid : up_ar_valid;
    assign dn_r_ready  = use_local ? um_r_ready : up_r_ready;

    assign um_aw_ready = use_local && dn_aw_ready;
    assign um_w_ready  = use_local && dn_w_ready;
    assign um_b_valid  = use_local && dn_b_valid;
    assign um_ar_ready = use_local && dn_ar_ready;
    assign um_r        = dn_r;
    assign um_r_valid  = use_local && dn_r_valid;

endmodule

`default_nettype wire

// ==== htif_console_bridge.sv ====
/* HTIF console bridge between a core's AXI master port and the system bus.
   UART-lite registers must be reachable on the downstream bus at uart_base. */
`default_nettype none

module htif_console_bridge import htif_pkg::*; #(
    parameter logic [63:0] tohost_addr   = 64'h0000_0000_8000_1000,
    parameter logic [63:0] fromhost_addr = 64'h0000_0000_8000_1040,
    parameter logic [63:0] uart_base     = 64'h0000_0000_1000_0000
) (
    input  logic       clk,
    input  logic       rst,
    input  axi_addr_t  up_aw,
    input  axi_wdata_t up_w,
    input  axi_addr_t  up_ar,
    input  logic       up_aw_valid, up_w_valid, up_b_ready, up_ar_valid, up_r_ready,
    output logic       up_aw_ready, up_w_ready, up_b_valid, up_ar_ready, up_r_valid,
    output axi_rdata_t up_r,
    output axi_addr_t  dn_aw,
    output axi_wdata_t dn_w,
    output axi_addr_t  dn_ar,
    output logic       dn_aw_valid, dn_w_valid, dn_b_ready, dn_ar_valid, dn_r_ready,
    input  logic       dn_aw_ready, dn_w_ready, dn_b_valid, dn_ar_ready, dn_r_valid,
    input  axi_rdata_t dn_r
);
    axi_addr_t   hs_aw, hs_ar, um_aw, um_ar;
    axi_wdata_t  hs_w, um_w;
    axi_rdata_t  hs_r, um_r;
    logic        hs_aw_valid, hs_w_valid, hs_b_ready, hs_ar_valid, hs_r_ready;
    logic        hs_aw_ready, hs_w_ready, hs_b_valid, hs_ar_ready, hs_r_valid;
    logic        um_aw_valid, um_w_valid, um_b_ready, um_ar_valid, um_r_ready;
    logic        um_aw_ready, um_w_ready, um_b_valid, um_ar_ready, um_r_valid;
    console_op_t op;
    logic        op_start, op_done, rx_valid, session_end;
    logic [7:0]  tx_byte, rx_byte;

    htif_axi_router #(
        .tohost_addr   (tohost_addr),
        .fromhost_addr (fromhost_addr)
    ) i_router (.*);

    htif_regs #(
        .tohost_addr   (tohost_addr),
        .fromhost_addr (fromhost_addr)
    ) i_regs (
        .clk         (clk),
        .rst         (rst),
        .aw          (hs_aw),
        .aw_valid    (hs_aw_valid),
        .aw_ready    (hs_aw_ready),
        .w           (hs_w),
        .w_valid     (hs_w_valid),
        .w_ready     (hs_w_ready),
        .b_valid     (hs_b_valid),
        .b_ready     (hs_b_ready),
        .ar          (hs_ar),
        .ar_valid    (hs_ar_valid),
        .ar_ready    (hs_ar_ready),
        .r           (hs_r),
        .r_valid     (hs_r_valid),
        .r_ready     (hs_r_ready),
        .op          (op),
        .op_start    (op_start),
        .tx_byte     (tx_byte),
        .op_done     (op_done),
        .rx_valid    (rx_valid),
        .rx_byte     (rx_byte),
        .session_end (session_end)
    );

    uart_lite_master #(
        .uart_base (uart_base)
    ) i_uart (
        .clk      (clk),
        .rst      (rst),
        .op       (op),
        .op_start (op_start),
        .tx_byte  (tx_byte),
        .aw       (um_aw),
        .aw_valid (um_aw_valid),
        .aw_ready (um_aw_ready),
        .w        (um_w),
        .w_valid  (um_w_valid),
        .w_ready  (um_w_ready),
        .b_valid  (um_b_valid),
        .b_ready  (um_b_ready),
        .ar       (um_ar),
        .ar_valid (um_ar_valid),
        .ar_ready (um_ar_ready),
        .r        (um_r),
        .r_valid  (um_r_valid),
        .r_ready  (um_r_ready),
        .op_done  (op_done),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte)
    );

endmodule

`default_nettype wire

// ==== tb_htif_console_bridge.sv ====
/* Testbench for the HTIF console bridge, random traffic from a fixed seed.
   Only one upstream transaction is open at a time, except a write held behind a console session. */
`default_nettype none

module tb_htif_console_bridge import htif_pkg::*; ();

    localparam logic [63:0] tohost_a     = 64'h0000_0000_8000_1000;
    localparam logic [63:0] fromhost_a   = 64'h0000_0000_8000_1040;
    localparam logic [63:0] uart_a       = 64'h0000_0000_1000_0000;
    localparam logic [63:0] mem_a        = 64'h0000_0000_8000_0000;
    localparam int          rand_seed    = 85;
    localparam int          n_trans      = 120;  // upper bound on upstream transactions
    localparam int          trans_cycles = 120;  // worst case per transaction

    logic       clk;
    logic       rst;
    axi_addr_t  up_aw, up_ar, dn_aw, dn_ar;
    axi_wdata_t up_w, dn_w;
    axi_rdata_t up_r, dn_r;
    logic       up_aw_valid, up_aw_ready, up_w_valid, up_w_ready, up_b_valid, up_b_ready;
    logic       up_ar_valid, up_ar_ready, up_r_valid, up_r_ready;
    logic       dn_aw_valid, dn_aw_ready, dn_w_valid, dn_w_ready, dn_b_valid, dn_b_ready;
    logic       dn_ar_valid, dn_ar_ready, dn_r_valid, dn_r_ready;
    integer     seed;

    // reference model, owned by the stimulus process
    logic [63:0] m_tohost, m_fromhost;
    logic [63:0] mem_exp [logic [63:0]];
    logic [7:0]  exp_chars [0:63];
    int          exp_tx_cnt, exp_stat_reads, exp_fifo_reads, m_rx_rd;
    int          full_req;                   // status reads to answer with Tx full
    logic [7:0]  rx_bytes [0:63];
    int          rx_wr;

    // bus and UART-lite model, owned by the bus process
    logic [63:0] mem [logic [63:0]];
    int          stat_reads, fifo_reads, tx_writes, full_used, rx_rd;
    int          wr_seq, tx_seq, last_mem_seq;

    htif_console_bridge #(
        .tohost_addr   (tohost_a),
        .fromhost_addr (fromhost_a),
        .uart_base     (uart_a)
    ) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #((16 + n_trans * trans_cycles) * 8);
        $display("Watchdog timeout, the DUT stopped answering before the tests were done");
        $display("Result: FAILED");
        $fatal(1);
    end

    task automatic check_eq(input logic [63:0] got, input logic [63:0] expv, input string what);
        if (got !== expv) begin
            $display("Fail at time %0t: %s, got %h, expected %h", $time, what, got, expv);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    // content of memory that was never written
    function automatic logic [63:0] fill(input logic [63:0] addr);
        return addr ^ {addr[31:0], addr[63:32]} ^ 64'h5a5a_0f0f_c3c3_9696;
    endfunction

    task automatic bus_write(input logic [63:0] addr, input logic [63:0] data,
                             input logic [7:0] strb);
        logic [63:0] old;
        wr_seq++;
        if (addr == uart_a) begin                               // Tx FIFO
            check_eq(64'(exp_tx_cnt > tx_writes), 64'd1, "unexpected UART Tx write");
            check_eq(64'(stat_reads), 64'(exp_stat_reads), "status reads before Tx write");
            check_eq({56'd0, strb}, {56'd0, 8'b0001_0000}, "Tx write strobe");
            check_eq({56'd0, data[39:32]}, {56'd0, exp_chars[tx_writes]}, "Tx character");
            tx_writes++;
            tx_seq = wr_seq;
        end else begin
            old = mem.exists(addr) ? mem[addr] : fill(addr);
            for (int i = 0; i < 8; i++) begin
                if (strb[i])
                    old[8*i +: 8] = data[8*i +: 8];
            end
            mem[addr] = old;
            last_mem_seq = wr_seq;
        end
    endtask

    task automatic bus_read(input logic [63:0] addr, output logic [63:0] data);
        data = '0;
        if (addr == uart_a + 64'd8) begin                       // status register
            stat_reads++;
            data[0] = rx_rd < rx_wr;
            data[3] = full_used < full_req;
            if (full_used < full_req)
                full_used++;
        end else if (addr == uart_a) begin                      // Rx FIFO
            fifo_reads++;
            if (rx_rd < rx_wr) begin
                data[7:0] = rx_bytes[rx_rd];
                rx_rd++;
            end
        end else begin
            data = mem.exists(addr) ? mem[addr] : fill(addr);
        end
    endtask

    // downstream slave with random ready and response delays
    initial begin : bus_model
        integer      bus_seed;
        logic [31:0] rnd;
        logic        aw_fire, w_fire, b_fire, ar_fire, r_fire;
        logic        have_aw, have_w, have_ar;
        logic [63:0] wa, wd, ra, rd;
        logic [7:0]  ws;
        bus_seed = rand_seed + 1;
        {dn_aw_ready, dn_w_ready, dn_b_valid, dn_ar_ready, dn_r_valid} = '0;
        dn_r = '0;
        {have_aw, have_w, have_ar} = '0;
        stat_reads = 0;
        fifo_reads = 0;
        tx_writes = 0;
        full_used = 0;
        rx_rd = 0;
        wr_seq = 0;
        tx_seq = 0;
        last_mem_seq = 0;
        @(negedge rst);
        forever begin
            @(negedge clk);
            aw_fire = dn_aw_valid && dn_aw_ready;
            w_fire  = dn_w_valid && dn_w_ready;
            b_fire  = dn_b_valid && dn_b_ready;
            ar_fire = dn_ar_valid && dn_ar_ready;
            r_fire  = dn_r_valid && dn_r_ready;
            if (aw_fire) begin
                wa = dn_aw.addr;
                check_eq(64'(dn_aw.len), 64'd0, "downstream AW burst length");
            end
            if (w_fire) begin
                wd = dn_w.data;
                ws = dn_w.strb;
                check_eq(64'(dn_w.last), 64'd1, "downstream W last flag");
            end
            if (ar_fire) begin
                ra = dn_ar.addr;
                check_eq(64'(dn_ar.len), 64'd0, "downstream AR burst length");
            end
            @(posedge clk);
            #1;
            rnd = $random(bus_seed);
            have_aw = have_aw || aw_fire;
            have_w  = have_w || w_fire;
            have_ar = have_ar || ar_fire;
            if (b_fire)
                dn_b_valid = 1'b0;
            if (r_fire)
                dn_r_valid = 1'b0;
            if (have_aw && have_w && !dn_b_valid && rnd[2]) begin
                bus_write(wa, wd, ws);
                {have_aw, have_w} = 2'b00;
                dn_b_valid = 1'b1;
            end
            if (have_ar && !dn_r_valid && rnd[3]) begin
                bus_read(ra, rd);
                dn_r.data = rd;
                dn_r.last = 1'b1;
                have_ar = 1'b0;
                dn_r_valid = 1'b1;
            end
            dn_aw_ready = !have_aw && rnd[0];
            dn_w_ready  = !have_w && rnd[1];
            dn_ar_ready = !have_ar && rnd[4];
        end
    end

    task automatic up_write(input logic [63:0] addr, input logic [63:0] data);
        logic aw_fire, w_fire, b_fire;
        up_aw.addr = addr;
        up_aw.len = 8'd0;
        up_w.data = data;
        up_w.strb = 8'hff;
        up_w.last = 1'b1;
        up_aw_valid = 1'b1;
        up_w_valid = 1'b1;
        up_b_ready = 1'b1;
        b_fire = 1'b0;
        while (!b_fire) begin
            @(negedge clk);
            aw_fire = up_aw_valid && up_aw_ready;
            w_fire  = up_w_valid && up_w_ready;
            b_fire  = up_b_valid && up_b_ready;
            @(posedge clk);
            #1;
            if (aw_fire)
                up_aw_valid = 1'b0;
            if (w_fire)
                up_w_valid = 1'b0;
        end
        up_b_ready = 1'b0;
    endtask

    task automatic up_read(input logic [63:0] addr, output logic [63:0] data);
        logic ar_fire, r_fire;
        up_ar.addr = addr;
        up_ar.len = 8'd0;
        up_ar_valid = 1'b1;
        up_r_ready = 1'b1;
        r_fire = 1'b0;
        data = '0;
        while (!r_fire) begin
            @(negedge clk);
            ar_fire = up_ar_valid && up_ar_ready;
            r_fire  = up_r_valid && up_r_ready;
            if (r_fire) begin
                data = up_r.data;
                check_eq(64'(up_r.last), 64'd1, "upstream R last flag");
            end
            @(posedge clk);
            #1;
            if (ar_fire)
                up_ar_valid = 1'b0;
        end
        up_r_ready = 1'b0;
    endtask

    task automatic do_write(input logic [63:0] addr, input logic [63:0] data, input int full);
        if (addr == tohost_a && data[63:48] == 16'h0101) begin    // console putchar
            full_req += full;
            exp_stat_reads += full + 1;
            exp_chars[exp_tx_cnt] = data[7:0];
            exp_tx_cnt++;
            m_tohost = '0;
        end else if (addr == tohost_a) begin
            m_tohost = data;
        end else if (addr == fromhost_a) begin
            m_fromhost = data;
        end else begin
            mem_exp[addr] = data;
        end
        up_write(addr, data);
    endtask

    task automatic do_read(input logic [63:0] addr, input string what);
        logic [63:0] expv, got;
        if (addr == tohost_a) begin
            expv = m_tohost;
        end else if (addr == fromhost_a) begin
            expv = m_fromhost;
            if (m_fromhost == '0) begin                          // starts a console poll
                exp_stat_reads++;
                if (m_rx_rd < rx_wr) begin
                    exp_fifo_reads++;
                    m_fromhost = {8'd1, 8'd0, 40'd0, rx_bytes[m_rx_rd]};
                    m_rx_rd++;
                end
            end
        end else begin
            expv = mem_exp.exists(addr) ? mem_exp[addr] : fill(addr);
        end
        up_read(addr, got);
        check_eq(got, expv, what);
    endtask

    // tohost read waits out any open session, then the UART counts are final
    task automatic check_uart(input string what);
        do_read(tohost_a, {what, ": tohost read"});
        check_eq(64'(stat_reads), 64'(exp_stat_reads), {what, ": status reads"});
        check_eq(64'(fifo_reads), 64'(exp_fifo_reads), {what, ": Rx FIFO reads"});
        check_eq(64'(tx_writes), 64'(exp_tx_cnt), {what, ": Tx FIFO writes"});
    endtask

    initial begin : stimulus
        logic [63:0] addr, data;
        logic [31:0] rnd, rnd2;
        seed = rand_seed;
        rst = 1'b1;
        up_aw = '0;
        up_w = '0;
        up_ar = '0;
        {up_aw_valid, up_w_valid, up_b_ready, up_ar_valid, up_r_ready} = '0;
        m_tohost = '0;
        m_fromhost = '0;
        exp_tx_cnt = 0;
        exp_stat_reads = 0;
        exp_fifo_reads = 0;
        m_rx_rd = 0;
        full_req = 0;
        rx_wr = 0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        repeat (40) begin                                        // pass-through
            rnd = $random(seed);
            addr = mem_a + {57'd0, rnd[7:4], 3'd0};
            data = {$random(seed), $random(seed)};
            if (rnd[0])
                do_write(addr, data, 0);
            else
                do_read(addr, "pass-through read");
        end
        check_uart("pass-through");

        repeat (4) begin                                         // plain register values
            data = {$random(seed), $random(seed)};
            if (data[63:48] == 16'h0101)
                data[48] = 1'b0;
            do_write(tohost_a, data, 0);
            do_read(tohost_a, "tohost read back");
            data[0] = 1'b1;                                      // nonzero, no poll
            do_write(fromhost_a, data, 0);
            do_read(fromhost_a, "fromhost read back");
        end
        check_uart("register values");

        repeat (4) begin                                         // console putchar
            rnd = $random(seed);
            rnd2 = $random(seed);
            data = {16'h0101, rnd2, 8'd0, rnd[7:0]};
            do_write(tohost_a, data, int'(rnd[9:8]));
            check_uart("console write");
        end

        do_write(fromhost_a, 64'd0, 0);
        repeat (4) begin                                         // console poll
            rnd = $random(seed);
            if (rnd[0]) begin
                rx_bytes[rx_wr] = rnd[15:8];
                rx_wr++;
            end
            do_read(fromhost_a, "fromhost read starting a poll");
            do_read(fromhost_a, "fromhost read after the poll");
            do_write(fromhost_a, 64'd0, 0);
            check_uart("console read");
        end

        repeat (2) begin                                         // write held by a session
            rnd = $random(seed);
            rnd2 = $random(seed);
            data = {16'h0101, rnd2, 8'd0, rnd[7:0]};
            do_write(tohost_a, data, 2 + int'(rnd[9:8]));
            addr = mem_a + {57'd0, rnd[13:10], 3'd0};
            do_write(addr, {$random(seed), $random(seed)}, 0);
            check_eq(64'(tx_writes == exp_tx_cnt && last_mem_seq > tx_seq), 64'd1,
                     "memory write before the UART write");
            do_read(addr, "memory data after the held write");
            check_uart("blocking");
        end

        if (exp_tx_cnt == tx_writes && rx_rd == rx_wr) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("UART model still holds work that the bridge never consumed");
            $display("Result: FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// ==== compile.f ====
htif_pkg.sv
htif_regs.sv
uart_lite_master.sv
htif_axi_router.sv
htif_console_bridge.sv
tb_htif_console_bridge.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of the console bridge testbench; the log decides pass or fail
rm -f sim.log
verilator --binary --timing --top-module tb_htif_console_bridge -f compile.f -o tb_sim \
    && { ./obj_dir/tb_sim > sim.log 2>&1 || true; } \
    && ! grep -q "Result: FAILED" sim.log \
    && grep -q "Result: PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
